// File: cache_consts.svh
`ifndef CACHE_CONSTS_SVH
`define CACHE_CONSTS_SVH

// system word and address
`define CACHE_ADDR_W     16
`define CACHE_DATA_W     16

// cache address split and geometry
`define CACHE_TAG_W      5
`define CACHE_INDEX_W    8
`define CACHE_OFFSET_W   3
`define CACHE_SETS       256
`define CACHE_LINE_WORDS 4
// wide enough for write-back and fill beats
`define CACHE_BEAT_W     3

// main memory, banks interleaved by word
`define MEM_BANKS        4
`define MEM_BANK_W       2
`define MEM_ROW_W        13
`define MEM_ROWS         8192
`define MEM_RD_LATENCY   2
// power-up word at byte address A holds A ^ key
`define MEM_FILL_KEY     16'h5a5a

`endif

// File: cache_pkg.sv
`include "cache_consts.svh"

package cache_pkg;

	// tag | index | byte offset
	typedef struct packed {
		logic [`CACHE_TAG_W-1:0]    tag;
		logic [`CACHE_INDEX_W-1:0]  index;
		logic [`CACHE_OFFSET_W-1:0] offset;
	} cache_view_t;

	// row | bank | byte bit
	typedef struct packed {
		logic [`MEM_ROW_W-1:0]  row;
		logic [`MEM_BANK_W-1:0] bank;
		logic                   byte_bit;
	} mem_view_t;

	// same address word, seen by the cache or by the banks
	typedef union packed {
		cache_view_t cache;
		mem_view_t   mem;
	} cache_addr_u;

	typedef struct packed {
		logic                       enable;
		logic                       cmp;
		logic                       wr;
		logic                       valid_in;
		logic [`CACHE_INDEX_W-1:0]  index;
		logic [`CACHE_OFFSET_W-1:0] offset;
		logic [`CACHE_TAG_W-1:0]    tag;
		logic [`CACHE_DATA_W-1:0]   data;
	} way_req_t;

	typedef struct packed {
		logic                     hit;
		logic                     dirty;
		logic                     valid;
		logic [`CACHE_TAG_W-1:0]  tag;
		logic [`CACHE_DATA_W-1:0] data;
	} way_resp_t;

	typedef struct packed {
		logic                     rd;
		logic                     wr;
		cache_addr_u              addr;
		logic [`CACHE_DATA_W-1:0] data;
	} mem_req_t;

endpackage

// File: cache_way.sv
`timescale 1ns/1ns
`include "cache_consts.svh"

module cache_way (
	input  logic                 clk,
	input  logic                 rst_n,
	input  cache_pkg::way_req_t  req,
	output cache_pkg::way_resp_t resp
);

	logic [`CACHE_DATA_W-1:0]   data_mem [`CACHE_SETS][`CACHE_LINE_WORDS];
	logic [`CACHE_TAG_W-1:0]    tag_mem [`CACHE_SETS];
	logic [`CACHE_SETS-1:0]     valid;
	logic [`CACHE_SETS-1:0]     dirty;
	logic [`CACHE_OFFSET_W-2:0] word;
	logic                       hit;
	logic                       cmp_wr;
	logic                       fill_wr;

	// byte offset to word within the line
	assign word = req.offset[`CACHE_OFFSET_W-1:1];

	assign hit = valid[req.index] & (tag_mem[req.index] == req.tag);

	// compare-write only lands on a hit
	assign cmp_wr = req.enable & req.wr & req.cmp & hit;
	assign fill_wr = req.enable & req.wr & ~req.cmp;

	always_comb
	begin
		resp.hit = hit;
		resp.dirty = dirty[req.index];
		resp.valid = valid[req.index];
		resp.tag = tag_mem[req.index];
		resp.data = data_mem[req.index][word];
	end

	always_ff @(posedge clk)
	begin
		if (cmp_wr | fill_wr)
		begin
			data_mem[req.index][word] <= req.data;
		end
		if (fill_wr)
		begin
			tag_mem[req.index] <= req.tag;
		end
	end

	// line state bits
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			valid <= '0;
			dirty <= '0;
		end
		else if (fill_wr)
		begin
			valid[req.index] <= req.valid_in;
			dirty[req.index] <= 1'b0;
		end
		else if (cmp_wr)
		begin
			dirty[req.index] <= 1'b1;
		end
	end

endmodule

// File: beat_counter.sv
`timescale 1ns/1ns
`include "cache_consts.svh"

module beat_counter (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     start,
	input  logic                     step,
	input  logic                     fill_phase,
	output logic [`CACHE_BEAT_W-1:0] beat,
	output logic                     last
);

	// write-back ends on the last word
	localparam logic [`CACHE_BEAT_W-1:0] WB_LAST = `CACHE_LINE_WORDS - 1;
	// fill runs on until the last read has returned
	localparam logic [`CACHE_BEAT_W-1:0] FILL_LAST = `CACHE_LINE_WORDS - 1 + `MEM_RD_LATENCY;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			beat <= '0;
		end
		else if (start)
		begin
			beat <= '0;
		end
		else if (step)
		begin
			beat <= beat + 1'b1;
		end
	end

	assign last = fill_phase ? (beat == FILL_LAST) : (beat == WB_LAST);

endmodule

// File: cache_controller.sv
`timescale 1ns/1ns
`include "cache_consts.svh"

module cache_controller (
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic                       rd,
	input  logic                       wr,
	input  cache_pkg::cache_addr_u     addr,
	input  logic [`CACHE_DATA_W-1:0]   data_in,
	input  cache_pkg::way_resp_t       way0,
	input  cache_pkg::way_resp_t       way1,
	input  logic [`CACHE_DATA_W-1:0]   mem_data,
	input  logic [`CACHE_BEAT_W-1:0]   beat,
	input  logic                       last,
	output cache_pkg::way_req_t        way0_req,
	output cache_pkg::way_req_t        way1_req,
	output cache_pkg::mem_req_t        mem_req,
	output logic                       cnt_start,
	output logic                       cnt_step,
	output logic                       fill_phase,
	output logic [`CACHE_DATA_W-1:0]   data_out,
	output logic                       done,
	output logic                       cache_hit,
	output logic                       stall
);

	localparam logic [1:0] ST_IDLE = 2'd0;
	localparam logic [1:0] ST_WB   = 2'd1;
	localparam logic [1:0] ST_FILL = 2'd2;

	logic [1:0]                 state;
	logic [1:0]                 next_state;
	logic                       victim_q;
	logic                       is_wr_q;
	logic [`CACHE_DATA_W-1:0]   data_q;
	logic [`CACHE_SETS-1:0]     lru;
	logic                       req_any;
	logic                       hit;
	logic                       victim;
	logic                       victim_dirty;
	logic [`CACHE_BEAT_W-1:0]   beat_wr;
	logic [`CACHE_OFFSET_W-2:0] fill_word;
	logic                       word_match;
	logic                       fill_wr;
	logic [`CACHE_DATA_W-1:0]   merged;
	logic                       en0;
	logic                       en1;
	cache_pkg::way_resp_t       victim_resp;
	cache_pkg::way_req_t        way_req;

	assign req_any = rd | wr;
	assign hit = way0.hit | way1.hit;

	// empty way first, else the one the lru bit names
	assign victim = ~way0.valid ? 1'b0 : (~way1.valid ? 1'b1 : lru[addr.cache.index]);
	assign victim_dirty = victim ? (way1.valid & way1.dirty) : (way0.valid & way0.dirty);
	assign victim_resp = victim_q ? way1 : way0;

	// cache writes trail the memory reads by the read latency
	assign beat_wr = beat - `CACHE_BEAT_W'(`MEM_RD_LATENCY);
	assign fill_word = beat_wr[`CACHE_OFFSET_W-2:0];
	assign fill_wr = (beat >= `CACHE_BEAT_W'(`MEM_RD_LATENCY));
	assign word_match = (fill_word == addr.cache.offset[`CACHE_OFFSET_W-1:1]);
	// requested word takes the store data on a write miss
	assign merged = (is_wr_q & word_match) ? data_in : mem_data;

	assign fill_phase = (state == ST_FILL);

	always_comb
	begin
		way_req = '0;
		way_req.index = addr.cache.index;
		way_req.offset = addr.cache.offset;
		way_req.tag = addr.cache.tag;
		way_req.data = data_in;
		en0 = 1'b0;
		en1 = 1'b0;
		mem_req = '0;
		mem_req.addr = addr;
		cnt_start = 1'b0;
		cnt_step = 1'b0;
		data_out = '0;
		done = 1'b0;
		cache_hit = 1'b0;
		stall = 1'b0;
		next_state = state;
		case (state)
			ST_IDLE:
			begin
				// both ways compare at once
				way_req.cmp = 1'b1;
				way_req.wr = wr;
				en0 = way0.hit;
				en1 = way1.hit & ~way0.hit;
				if (way0.hit)
				begin
					data_out = way0.data;
				end
				else if (way1.hit)
				begin
					data_out = way1.data;
				end
				done = req_any & hit;
				cache_hit = req_any & hit;
				stall = req_any & ~hit;
				if (req_any & ~hit)
				begin
					cnt_start = 1'b1;
					next_state = victim_dirty ? ST_WB : ST_FILL;
				end
			end
			ST_WB:
			begin
				// victim word out to its own line in memory
				way_req.offset = {beat[`CACHE_OFFSET_W-2:0], 1'b0};
				mem_req.wr = 1'b1;
				mem_req.addr.cache.tag = victim_resp.tag;
				mem_req.addr.cache.offset = {beat[`CACHE_OFFSET_W-2:0], 1'b0};
				mem_req.data = victim_resp.data;
				stall = 1'b1;
				if (last)
				begin
					cnt_start = 1'b1;
					next_state = ST_FILL;
				end
				else
				begin
					cnt_step = 1'b1;
				end
			end
			ST_FILL:
			begin
				mem_req.rd = (beat < `CACHE_BEAT_W'(`CACHE_LINE_WORDS));
				mem_req.addr.cache.offset = {beat[`CACHE_OFFSET_W-2:0], 1'b0};
				if (fill_wr)
				begin
					way_req.wr = 1'b1;
					way_req.valid_in = 1'b1;
					// last beat of a write miss goes as a compare write to set dirty
					way_req.cmp = is_wr_q & last;
					way_req.offset = {fill_word, 1'b0};
					way_req.data = merged;
					en0 = ~victim_q;
					en1 = victim_q;
				end
				if (last)
				begin
					done = 1'b1;
					data_out = word_match ? merged : data_q;
					next_state = ST_IDLE;
				end
				else
				begin
					stall = 1'b1;
					cnt_step = 1'b1;
				end
			end
			default:
			begin
				next_state = ST_IDLE;
			end
		endcase
		way0_req = way_req;
		way0_req.enable = en0;
		way1_req = way_req;
		way1_req.enable = en1;
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state <= ST_IDLE;
			victim_q <= 1'b0;
			is_wr_q <= 1'b0;
			lru <= '0;
		end
		else
		begin
			state <= next_state;
			if (state == ST_IDLE && req_any)
			begin
				if (hit)
				begin
					// point lru at the way not used
					lru[addr.cache.index] <= way0.hit;
				end
				else
				begin
					victim_q <= victim;
					is_wr_q <= wr;
				end
			end
			if (state == ST_FILL && last)
			begin
				lru[addr.cache.index] <= ~victim_q;
			end
		end
	end

	// keep the requested word as it goes by
	always_ff @(posedge clk)
	begin
		if (state == ST_FILL && fill_wr && word_match)
		begin
			data_q <= merged;
		end
	end

endmodule

// File: four_bank_mem.sv
`timescale 1ns/1ns
`include "cache_consts.svh"

module four_bank_mem (
	input  logic                     clk,
	input  logic                     rst_n,
	input  cache_pkg::mem_req_t      req,
	output logic [`CACHE_DATA_W-1:0] rd_data
);

	logic [`CACHE_DATA_W-1:0]   bank [`MEM_BANKS][`MEM_ROWS];
	logic [`MEM_RD_LATENCY-1:0] rd_valid;
	logic [`CACHE_DATA_W-1:0]   rd_pipe [`MEM_RD_LATENCY];

	// power-up contents follow the fill key
	initial
	begin
		for (int b = 0; b < `MEM_BANKS; b++)
		begin
			for (int r = 0; r < `MEM_ROWS; r++)
			begin
				bank[b][r] = {r[`MEM_ROW_W-1:0], b[`MEM_BANK_W-1:0], 1'b0} ^ `MEM_FILL_KEY;
			end
		end
	end

	always @(posedge clk)
	begin
		if (req.wr)
		begin
			bank[req.addr.mem.bank][req.addr.mem.row] <= req.data;
		end
	end

	// read pipeline, one read may issue every cycle
	always_ff @(posedge clk)
	begin
		if (req.rd)
		begin
			rd_pipe[0] <= bank[req.addr.mem.bank][req.addr.mem.row];
		end
		for (int i = 1; i < `MEM_RD_LATENCY; i++)
		begin
			if (rd_valid[i-1])
			begin
				rd_pipe[i] <= rd_pipe[i-1];
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			rd_valid <= '0;
		end
		else
		begin
			rd_valid <= {rd_valid[`MEM_RD_LATENCY-2:0], req.rd};
		end
	end

	assign rd_data = rd_valid[`MEM_RD_LATENCY-1] ? rd_pipe[`MEM_RD_LATENCY-1] : '0;

endmodule

// File: cache_top.sv
`timescale 1ns/1ns
`include "cache_consts.svh"

module cache_top (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     rd,
	input  logic                     wr,
	input  cache_pkg::cache_addr_u   addr,
	input  logic [`CACHE_DATA_W-1:0] data_in,
	output logic [`CACHE_DATA_W-1:0] data_out,
	output logic                     done,
	output logic                     cache_hit,
	output logic                     stall
);

	cache_pkg::way_req_t      way0_req;
	cache_pkg::way_req_t      way1_req;
	cache_pkg::way_resp_t     way0_resp;
	cache_pkg::way_resp_t     way1_resp;
	cache_pkg::mem_req_t      mem_req;
	logic [`CACHE_DATA_W-1:0] mem_data;
	logic [`CACHE_BEAT_W-1:0] beat;
	logic                     last;
	logic                     cnt_start;
	logic                     cnt_step;
	logic                     fill_phase;

	cache_controller u_ctrl (
		.clk        (clk),
		.rst_n      (rst_n),
		.rd         (rd),
		.wr         (wr),
		.addr       (addr),
		.data_in    (data_in),
		.way0       (way0_resp),
		.way1       (way1_resp),
		.mem_data   (mem_data),
		.beat       (beat),
		.last       (last),
		.way0_req   (way0_req),
		.way1_req   (way1_req),
		.mem_req    (mem_req),
		.cnt_start  (cnt_start),
		.cnt_step   (cnt_step),
		.fill_phase (fill_phase),
		.data_out   (data_out),
		.done       (done),
		.cache_hit  (cache_hit),
		.stall      (stall)
	);

	beat_counter u_beats (
		.clk        (clk),
		.rst_n      (rst_n),
		.start      (cnt_start),
		.step       (cnt_step),
		.fill_phase (fill_phase),
		.beat       (beat),
		.last       (last)
	);

	cache_way u_way0 (
		.clk   (clk),
		.rst_n (rst_n),
		.req   (way0_req),
		.resp  (way0_resp)
	);

	cache_way u_way1 (
		.clk   (clk),
		.rst_n (rst_n),
		.req   (way1_req),
		.resp  (way1_resp)
	);

	four_bank_mem u_mem (
		.clk     (clk),
		.rst_n   (rst_n),
		.req     (mem_req),
		.rd_data (mem_data)
	);

endmodule

// File: cache_top_checker.sv
`timescale 1ns/1ns
`include "cache_consts.svh"

module cache_top_checker (
	input logic                     clk,
	input logic                     rst_n,
	input logic                     done,
	input logic                     stall,
	input logic                     cache_hit,
	input logic [`CACHE_DATA_W-1:0] data_out,
	input cache_pkg::mem_req_t      mem_req
);

	int failures;

	initial
	begin
		failures = 0;
	end

	done_stall_excl: assert property (@(posedge clk) disable iff (!rst_n)
		!(done && stall))
	else
	begin
		$error("done and stall are high in the same cycle");
		failures++;
	end

	mem_strobe_excl: assert property (@(posedge clk) disable iff (!rst_n)
		!(mem_req.rd && mem_req.wr))
	else
	begin
		$error("memory read and write strobes are high together");
		failures++;
	end

	// a miss keeps stall up until its done cycle
	stall_until_done: assert property (@(posedge clk) disable iff (!rst_n)
		stall |=> (stall || done))
	else
	begin
		$error("stall dropped before done");
		failures++;
	end

	outputs_known: assert property (@(posedge clk) disable iff (!rst_n)
		!$isunknown({done, stall, cache_hit, data_out, mem_req.rd, mem_req.wr}))
	else
	begin
		$error("an output is unknown after reset");
		failures++;
	end

endmodule

bind cache_top cache_top_checker u_checker (
	.clk       (clk),
	.rst_n     (rst_n),
	.done      (done),
	.stall     (stall),
	.cache_hit (cache_hit),
	.data_out  (data_out),
	.mem_req   (mem_req)
);

// File: cache_top_tb.sv
`timescale 1ns/1ns
`include "cache_consts.svh"

module cache_top_tb;

	// about 240 accesses at no more than 12 cycles each, plus margin
	localparam int MAX_CYCLES = 4000;
	localparam int NUM_RANDOM = 200;

	logic                     clk;
	logic                     rst_n;
	logic                     rd;
	logic                     wr;
	cache_pkg::cache_addr_u   addr;
	logic [`CACHE_DATA_W-1:0] data_in;
	logic [`CACHE_DATA_W-1:0] data_out;
	logic                     done;
	logic                     cache_hit;
	logic                     stall;

	int errors;
	int checks;
	int cycles;
	integer seed;

	// reference model of memory words, set tags and lru
	logic [`CACHE_DATA_W-1:0] mem_model [1 << (`CACHE_ADDR_W - 1)];
	logic [`CACHE_TAG_W-1:0]  tag_m [`CACHE_SETS][2];
	logic                     valid_m [`CACHE_SETS][2];
	logic                     dirty_m [`CACHE_SETS][2];
	logic                     lru_m [`CACHE_SETS];

	cache_top u_cache_top (
		.clk       (clk),
		.rst_n     (rst_n),
		.rd        (rd),
		.wr        (wr),
		.addr      (addr),
		.data_in   (data_in),
		.data_out  (data_out),
		.done      (done),
		.cache_hit (cache_hit),
		.stall     (stall)
	);

	initial
	begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	initial
	begin
		cycles = 0;
		forever
		begin
			@(posedge clk);
			cycles++;
			if (cycles >= MAX_CYCLES)
			begin
				$display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
				$display("Errors found");
				$finish;
			end
		end
	end

	task automatic compare_value(input string name, input logic [15:0] expected,
		input logic [15:0] actual);
		checks++;
		if (expected !== actual)
		begin
			errors++;
			$display("mismatch %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
		end
	endtask

	function automatic cache_pkg::cache_addr_u make_addr(input logic [4:0] tag,
		input logic [7:0] index, input logic [1:0] word);
		cache_pkg::cache_addr_u a;
		a.cache.tag = tag;
		a.cache.index = index;
		a.cache.offset = {word, 1'b0};
		return a;
	endfunction

	// expected hit and latency, then update of the model state
	task automatic predict(input logic is_wr, input cache_pkg::cache_addr_u a,
		input logic [15:0] d, output logic exp_hit, output int exp_lat);
		logic [7:0] idx;
		logic       way;
		idx = a.cache.index;
		exp_hit = 1'b1;
		if (valid_m[idx][0] && tag_m[idx][0] == a.cache.tag)
			way = 1'b0;
		else if (valid_m[idx][1] && tag_m[idx][1] == a.cache.tag)
			way = 1'b1;
		else
			exp_hit = 1'b0;
		if (exp_hit)
		begin
			exp_lat = 0;
			lru_m[idx] = (way == 1'b0);
			if (is_wr)
				dirty_m[idx][way] = 1'b1;
		end
		else
		begin
			way = !valid_m[idx][0] ? 1'b0 : (!valid_m[idx][1] ? 1'b1 : lru_m[idx]);
			exp_lat = (valid_m[idx][way] && dirty_m[idx][way]) ? 10 : 6;
			valid_m[idx][way] = 1'b1;
			tag_m[idx][way] = a.cache.tag;
			dirty_m[idx][way] = is_wr;
			lru_m[idx] = ~way;
		end
		if (is_wr)
			mem_model[{a.mem.row, a.mem.bank}] = d;
	endtask

	// drives one request, waits for done and measures the latency in cycles
	task automatic access(input logic is_wr, input cache_pkg::cache_addr_u a,
		input logic [15:0] d, output logic [15:0] rdata, output logic hit, output int lat,
		output int stalled);
		rd = ~is_wr;
		wr = is_wr;
		addr = a;
		data_in = d;
		lat = 0;
		stalled = 0;
		@(negedge clk);
		while (!done)
		begin
			if (stall)
				stalled++;
			@(negedge clk);
			lat++;
		end
		rdata = data_out;
		hit = cache_hit;
		@(posedge clk);
		#5;
		rd = 1'b0;
		wr = 1'b0;
	endtask

	task automatic run_access(input string name, input logic is_wr,
		input cache_pkg::cache_addr_u a, input logic [15:0] d,
		output logic [15:0] rdata, output logic hit, output int lat);
		logic [15:0] exp_data;
		logic        exp_hit;
		int          exp_lat;
		int          stalled;
		exp_data = is_wr ? d : mem_model[{a.mem.row, a.mem.bank}];
		predict(is_wr, a, d, exp_hit, exp_lat);
		access(is_wr, a, d, rdata, hit, lat, stalled);
		// a write miss hands back the stored word
		if (!is_wr || !exp_hit)
			compare_value({name, " data"}, exp_data, rdata);
		compare_value({name, " hit"}, exp_hit, hit);
		compare_value({name, " latency"}, exp_lat, lat);
		compare_value({name, " stall cycles"}, exp_lat, stalled);
	endtask

	task automatic read_miss_then_hit();
		cache_pkg::cache_addr_u a;
		logic [15:0]            q;
		logic                   h;
		int                     lat;
		a = make_addr(5'd3, 8'h10, 2'd1);
		run_access("cold read", 1'b0, a, 16'h0, q, h, lat);
		compare_value("cold read key word", a ^ `MEM_FILL_KEY, q);
		compare_value("cold read done cycle", 16'd6, lat);
		a = make_addr(5'd3, 8'h10, 2'd2);
		run_access("same line read", 1'b0, a, 16'h0, q, h, lat);
		compare_value("same line read hit", 1'b1, h);
		compare_value("same line done cycle", 16'd0, lat);
	endtask

	task automatic write_hit_readback();
		cache_pkg::cache_addr_u a;
		logic [15:0]            q;
		logic                   h;
		int                     lat;
		a = make_addr(5'd3, 8'h10, 2'd0);
		run_access("write hit", 1'b1, a, 16'hbeef, q, h, lat);
		compare_value("write hit flag", 1'b1, h);
		run_access("write hit readback", 1'b0, a, 16'h0, q, h, lat);
		compare_value("write hit readback value", 16'hbeef, q);
	endtask

	task automatic write_miss_allocate();
		cache_pkg::cache_addr_u a;
		logic [15:0]            q;
		logic                   h;
		int                     lat;
		a = make_addr(5'd7, 8'h20, 2'd2);
		run_access("write miss", 1'b1, a, 16'h1234, q, h, lat);
		compare_value("write miss flag", 1'b0, h);
		run_access("write miss readback", 1'b0, a, 16'h0, q, h, lat);
		compare_value("write miss readback value", 16'h1234, q);
		compare_value("write miss readback hit", 1'b1, h);
		for (int w = 0; w < `CACHE_LINE_WORDS; w++)
		begin
			if (w != 2)
			begin
				a = make_addr(5'd7, 8'h20, w[1:0]);
				run_access("write miss neighbour", 1'b0, a, 16'h0, q, h, lat);
				compare_value("neighbour key word", a ^ `MEM_FILL_KEY, q);
			end
		end
	endtask

	task automatic dirty_writeback();
		logic [15:0] q;
		logic        h;
		int          lat;
		run_access("dirty tag a", 1'b1, make_addr(5'd1, 8'h30, 2'd1), 16'hcafe, q, h, lat);
		run_access("fill tag b", 1'b0, make_addr(5'd2, 8'h30, 2'd0), 16'h0, q, h, lat);
		run_access("evict tag a", 1'b0, make_addr(5'd4, 8'h30, 2'd3), 16'h0, q, h, lat);
		compare_value("dirty miss done cycle", 16'd10, lat);
		run_access("reread tag a", 1'b0, make_addr(5'd1, 8'h30, 2'd1), 16'h0, q, h, lat);
		compare_value("reread tag a hit", 1'b0, h);
		compare_value("written back value", 16'hcafe, q);
	endtask

	task automatic lru_replacement();
		logic [15:0] q;
		logic        h;
		int          lat;
		run_access("lru fill a", 1'b0, make_addr(5'd1, 8'h40, 2'd0), 16'h0, q, h, lat);
		run_access("lru fill b", 1'b0, make_addr(5'd2, 8'h40, 2'd0), 16'h0, q, h, lat);
		run_access("lru touch a", 1'b0, make_addr(5'd1, 8'h40, 2'd1), 16'h0, q, h, lat);
		run_access("lru miss c", 1'b0, make_addr(5'd3, 8'h40, 2'd0), 16'h0, q, h, lat);
		run_access("lru reread a", 1'b0, make_addr(5'd1, 8'h40, 2'd2), 16'h0, q, h, lat);
		compare_value("lru a kept", 1'b1, h);
		run_access("lru reread b", 1'b0, make_addr(5'd2, 8'h40, 2'd2), 16'h0, q, h, lat);
		compare_value("lru b evicted", 1'b0, h);
	endtask

	task automatic random_mix();
		cache_pkg::cache_addr_u a;
		logic [15:0]            q;
		logic                   h;
		int                     lat;
		logic                   is_wr;
		logic [15:0]            d;
		for (int i = 0; i < NUM_RANDOM; i++)
		begin
			// eight tags over four sets keeps evictions frequent
			a = make_addr($random(seed) & 7, 8'h50 + ($random(seed) & 3), $random(seed) & 3);
			is_wr = $random(seed) & 1;
			d = $random(seed);
			run_access("random mix", is_wr, a, d, q, h, lat);
		end
	endtask

	initial
	begin
		errors = 0;
		checks = 0;
		seed = 32'hb83dae6b;
		rst_n = 1'b0;
		rd = 1'b0;
		wr = 1'b0;
		addr = '0;
		data_in = '0;
		for (int i = 0; i < (1 << (`CACHE_ADDR_W - 1)); i++)
			mem_model[i] = {i[14:0], 1'b0} ^ `MEM_FILL_KEY;
		for (int s = 0; s < `CACHE_SETS; s++)
		begin
			lru_m[s] = 1'b0;
			for (int w = 0; w < 2; w++)
			begin
				valid_m[s][w] = 1'b0;
				dirty_m[s][w] = 1'b0;
				tag_m[s][w] = '0;
			end
		end
		repeat (4) @(posedge clk);
		#5;
		rst_n = 1'b1;
		@(posedge clk);
		#5;
		compare_value("reset done", 1'b0, done);
		compare_value("reset stall", 1'b0, stall);
		compare_value("reset hit", 1'b0, cache_hit);
		read_miss_then_hit();
		write_hit_readback();
		write_miss_allocate();
		dirty_writeback();
		lru_replacement();
		random_mix();
		errors += u_cache_top.u_checker.failures;
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

// File: cache_top.f
+incdir+.
cache_pkg.sv
cache_way.sv
beat_counter.sv
cache_controller.sv
four_bank_mem.sv
cache_top.sv
cache_top_checker.sv
cache_top_tb.sv
